// ==== Bender.yml ====
package:
  name: regfile_alu

sources:
  # rtl, package first
  - files:
      - logic/regfile_alu_pkg.sv
      - logic/hct74670.sv
      - logic/register_file.sv
      - logic/alu.sv
      - logic/regfile_alu_top.sv

  # testbench, checker before the top
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/regfile_alu_sva.sv
      - sim/regfile_alu_tb.sv

### tops
### testbench: regfile_alu_tb
### rtl: regfile_alu_top

// ==== logic/alu.sv ====
// registered alu on the two read ports or left port plus immediate, with carry and zero
module alu
    import regfile_alu_pkg::*;
#(
    parameter int DATA_WIDTH = regfile_alu_pkg::DATA_WIDTH
) (
    input  logic                  _wr_en,
    input  logic                  arst_n,
    input  alu_instr_u            instr,
    input  logic [DATA_WIDTH-1:0] l_operand,
    input  logic [DATA_WIDTH-1:0] r_operand,
    output logic [DATA_WIDTH-1:0] result,
    output logic                  carry,
    output logic                  zero
);

    logic                  is_imm;
    alu_op_t               op;
    logic [DATA_WIDTH-1:0] r_sel;
    // one bit wider than the word for carry and borrow
    logic [DATA_WIDTH:0]   alu_ext;
    logic                  carry_next;

    // instruction decode
    // is_imm picks which view of the word applies
    always_comb begin
        is_imm = instr.reg_form.is_imm;
        op     = instr.reg_form.op;
        if (is_imm) begin
            // imm is 8 bits, zero-extended or cut to the word
            r_sel = DATA_WIDTH'(instr.imm_form.imm);
        end else begin
            r_sel = r_operand;
        end
    end

    // datapath
    always_comb begin
        case (op)
            OP_ADD:    alu_ext = {1'b0, l_operand} + {1'b0, r_sel};
            // top bit set on borrow
            OP_SUB:    alu_ext = {1'b0, l_operand} - {1'b0, r_sel};
            OP_AND:    alu_ext = {1'b0, l_operand & r_sel};
            OP_OR:     alu_ext = {1'b0, l_operand | r_sel};
            OP_XOR:    alu_ext = {1'b0, l_operand ^ r_sel};
            OP_PASS_L: alu_ext = {1'b0, l_operand};
            OP_PASS_R: alu_ext = {1'b0, r_sel};
            OP_INC_L:  alu_ext = {1'b0, l_operand} + 1'b1;
            default:   alu_ext = '0;
        endcase
    end

    // only arithmetic ops produce a carry
    always_comb begin
        case (op)
            OP_ADD, OP_SUB, OP_INC_L: carry_next = alu_ext[DATA_WIDTH];
            default:                  carry_next = 1'b0;
        endcase
    end

    // result and flags register
    always_ff @(posedge _wr_en or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
            carry  <= 1'b0;
            zero   <= 1'b0;
        end else begin
            result <= alu_ext[DATA_WIDTH-1:0];
            carry  <= carry_next;
            zero   <= ~|alu_ext[DATA_WIDTH-1:0];
        end
    end

endmodule

// ==== logic/hct74670.sv ====
// 74hct670 model, 4 words by 4 bits with one write port and one read port
module hct74670 (
    input  logic       _wr_en,
    input  logic       arst_n,
    input  logic       we,
    input  logic [1:0] wr_addr,
    input  logic [3:0] wr_data,
    input  logic       _rd_en,
    input  logic [1:0] rd_addr,
    output logic [3:0] rd_data
);

    // four nibbles of storage
    logic [3:0] regs [4];

    // write side
    // the real part writes on a low strobe, here the rising edge of
    // _wr_en commits the word when we is high
    always_ff @(posedge _wr_en or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= 4'h0;
            end
        end else if (we) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // read side
    // the real output goes high-z when disabled and the bus is pulled
    // down, so a disabled port simply reads zero
    always_comb begin
        if (_rd_en) begin
            rd_data = 4'h0;
        end else begin
            rd_data = regs[rd_addr];
        end
    end

endmodule

// ==== logic/regfile_alu_pkg.sv ====
// shared widths, alu opcodes and the alu instruction word for the regfile/alu slice
package regfile_alu_pkg;

    // default word width, overridden from the top level
    parameter int DATA_WIDTH = 8;

    // four words in the file
    parameter int ADDR_WIDTH = 2;

    // data width of one 74670 chip
    parameter int NIBBLE = 4;

    // alu operations
    typedef enum logic [2:0] {
        OP_ADD    = 3'd0,
        OP_SUB    = 3'd1,
        OP_AND    = 3'd2,
        OP_OR     = 3'd3,
        OP_XOR    = 3'd4,
        OP_PASS_L = 3'd5,
        OP_PASS_R = 3'd6,
        OP_INC_L  = 3'd7
    } alu_op_t;

    // 12-bit instruction word, two views of the same bits
    // is_imm and op sit at the top in both views
    typedef union packed {
        // register form, right operand comes from the right read port
        struct packed {
            logic       is_imm;
            alu_op_t    op;
            logic [7:0] unused;
        } reg_form;

        // immediate form, low byte replaces the right operand
        struct packed {
            logic       is_imm;
            alu_op_t    op;
            logic [7:0] imm;
        } imm_form;
    } alu_instr_u;

endpackage

// ==== logic/regfile_alu_top.sv ====
// datapath slice top, dual-read register file feeding a registered alu
module regfile_alu_top
    import regfile_alu_pkg::*;
#(
    parameter int DATA_WIDTH = regfile_alu_pkg::DATA_WIDTH
) (
    input  logic                  _wr_en,
    input  logic                  arst_n,

    // write side
    input  logic                  we,
    input  logic [ADDR_WIDTH-1:0] wr_addr,
    input  logic [DATA_WIDTH-1:0] wr_data,

    // left read port
    input  logic                  _rdl_en,
    input  logic [ADDR_WIDTH-1:0] rdl_addr,
    output logic [DATA_WIDTH-1:0] rdl_data,

    // right read port
    input  logic                  _rdr_en,
    input  logic [ADDR_WIDTH-1:0] rdr_addr,
    output logic [DATA_WIDTH-1:0] rdr_data,

    // alu
    input  alu_instr_u            instr,
    output logic [DATA_WIDTH-1:0] result,
    output logic                  carry,
    output logic                  zero
);

    register_file #(
        .DATA_WIDTH (DATA_WIDTH)
    ) register_file_inst (
        ._wr_en   (_wr_en),
        .arst_n   (arst_n),
        .we       (we),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        ._rdl_en  (_rdl_en),
        .rdl_addr (rdl_addr),
        ._rdr_en  (_rdr_en),
        .rdr_addr (rdr_addr),
        .rdl_data (rdl_data),
        .rdr_data (rdr_data)
    );

    // read ports double as alu operands
    alu #(
        .DATA_WIDTH (DATA_WIDTH)
    ) alu_inst (
        ._wr_en    (_wr_en),
        .arst_n    (arst_n),
        .instr     (instr),
        .l_operand (rdl_data),
        .r_operand (rdr_data),
        .result    (result),
        .carry     (carry),
        .zero      (zero)
    );

endmodule

// ==== logic/register_file.sv ====
// 4-word dual-read register file built from paired 74670 chips per read port
module register_file
    import regfile_alu_pkg::*;
#(
    parameter int DATA_WIDTH = regfile_alu_pkg::DATA_WIDTH
) (
    input  logic                  _wr_en,
    input  logic                  arst_n,
    input  logic                  we,
    input  logic [ADDR_WIDTH-1:0] wr_addr,
    input  logic [DATA_WIDTH-1:0] wr_data,
    input  logic                  _rdl_en,
    input  logic [ADDR_WIDTH-1:0] rdl_addr,
    input  logic                  _rdr_en,
    input  logic [ADDR_WIDTH-1:0] rdr_addr,
    output logic [DATA_WIDTH-1:0] rdl_data,
    output logic [DATA_WIDTH-1:0] rdr_data
);

    // chips per bank, one per nibble of the word
    localparam int NUM_CHIPS = DATA_WIDTH / NIBBLE;

    // word must split into whole chips
    if (DATA_WIDTH % NIBBLE != 0) begin : g_width_check
        $error("register_file: DATA_WIDTH %0d is not a multiple of %0d",
               DATA_WIDTH, NIBBLE);
    end

    // left bank
    // every chip sees the same write strobe and address, only its nibble
    for (genvar i = 0; i < NUM_CHIPS; i++) begin : g_bank_l
        hct74670 chip_inst (
            ._wr_en  (_wr_en),
            .arst_n  (arst_n),
            .we      (we),
            .wr_addr (wr_addr),
            .wr_data (wr_data[i*NIBBLE +: NIBBLE]),
            ._rd_en  (_rdl_en),
            .rd_addr (rdl_addr),
            .rd_data (rdl_data[i*NIBBLE +: NIBBLE])
        );
    end

    // right bank
    // shares the write side with the left bank, so contents stay identical
    for (genvar i = 0; i < NUM_CHIPS; i++) begin : g_bank_r
        hct74670 chip_inst (
            ._wr_en  (_wr_en),
            .arst_n  (arst_n),
            .we      (we),
            .wr_addr (wr_addr),
            .wr_data (wr_data[i*NIBBLE +: NIBBLE]),
            ._rd_en  (_rdr_en),
            .rd_addr (rdr_addr),
            .rd_data (rdr_data[i*NIBBLE +: NIBBLE])
        );
    end

endmodule

// ==== regfile_alu.f ====
logic/regfile_alu_pkg.sv
logic/hct74670.sv
logic/register_file.sv
logic/alu.sv
logic/regfile_alu_top.sv
sim/tb_clock_gen.sv
sim/regfile_alu_sva.sv
sim/regfile_alu_tb.sv

// ==== sim/regfile_alu_sva.sv ====
// bound checker for the regfile/alu slice, shadow register model and alu reference
module regfile_alu_sva
    import regfile_alu_pkg::*;
#(
    parameter int DATA_WIDTH = regfile_alu_pkg::DATA_WIDTH
) (
    input logic                  _wr_en,
    input logic                  arst_n,
    input logic                  we,
    input logic [ADDR_WIDTH-1:0] wr_addr,
    input logic [DATA_WIDTH-1:0] wr_data,
    input logic                  _rdl_en,
    input logic [ADDR_WIDTH-1:0] rdl_addr,
    input logic [DATA_WIDTH-1:0] rdl_data,
    input logic                  _rdr_en,
    input logic [ADDR_WIDTH-1:0] rdr_addr,
    input logic [DATA_WIDTH-1:0] rdr_data,
    input alu_instr_u            instr,
    input logic [DATA_WIDTH-1:0] result,
    input logic                  carry,
    input logic                  zero
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [DATA_WIDTH-1:0] shadow [4];
    logic [DATA_WIDTH-1:0] exp_left;
    logic [DATA_WIDTH-1:0] exp_right;
    // operands and instr as they stood before the last edge
    logic [DATA_WIDTH-1:0] l_q;
    logic [DATA_WIDTH-1:0] r_q;
    alu_instr_u            instr_q;
    logic                  q_valid;
    logic [DATA_WIDTH-1:0] exp_word;
    logic                  exp_carry;
    int                    fail_count = 0;

    // reference alu, carry from unsigned compares
    function automatic logic [DATA_WIDTH:0] expect_alu(
        input logic [DATA_WIDTH-1:0] l,
        input logic [DATA_WIDTH-1:0] r,
        input alu_instr_u            ins
    );
        logic [DATA_WIDTH-1:0] rhs;
        logic [DATA_WIDTH-1:0] word;
        logic                  cy;
        rhs = ins.imm_form.is_imm ? DATA_WIDTH'(ins.imm_form.imm) : r;
        cy  = 1'b0;
        case (ins.reg_form.op)
            OP_ADD: begin
                word = l + rhs;
                // wrapped sum below an addend means overflow
                cy   = (word < l);
            end
            OP_SUB: begin
                word = l - rhs;
                cy   = (l < rhs);
            end
            OP_AND:    word = l & rhs;
            OP_OR:     word = l | rhs;
            OP_XOR:    word = l ^ rhs;
            OP_PASS_L: word = l;
            OP_PASS_R: word = rhs;
            OP_INC_L: begin
                word = l + 1'b1;
                cy   = (l == '1);
            end
            default:   word = '0;
        endcase
        return {cy, word};
    endfunction

    always_ff @(posedge _wr_en or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 4; i++) begin
                shadow[i] <= '0;
            end
            l_q     <= '0;
            r_q     <= '0;
            instr_q <= '0;
            q_valid <= 1'b0;
        end else begin
            if (we) begin
                shadow[wr_addr] <= wr_data;
            end
            l_q     <= rdl_data;
            r_q     <= rdr_data;
            instr_q <= instr;
            q_valid <= 1'b1;
        end
    end

    // disabled port reads zero
    assign exp_left  = _rdl_en ? '0 : shadow[rdl_addr];
    assign exp_right = _rdr_en ? '0 : shadow[rdr_addr];
    assign {exp_carry, exp_word} = expect_alu(l_q, r_q, instr_q);

    a_left_read: assert property (
        @(posedge _wr_en) disable iff (!arst_n) rdl_data == exp_left
    ) else begin
        $error("ERR %0t: left port read %0h, expected %0h", $time,
               $sampled(rdl_data), $sampled(exp_left));
        fail_count++;
    end

    a_right_read: assert property (
        @(posedge _wr_en) disable iff (!arst_n) rdr_data == exp_right
    ) else begin
        $error("ERR %0t: right port read %0h, expected %0h", $time,
               $sampled(rdr_data), $sampled(exp_right));
        fail_count++;
    end

    // first edge out of reset still shows the cleared register
    a_alu_reset: assert property (
        @(posedge _wr_en) disable iff (!arst_n)
        !q_valid |-> (result == '0 && !carry && !zero)
    ) else begin
        $error("ERR %0t: alu outputs not cleared by reset", $time);
        fail_count++;
    end

    a_alu_result: assert property (
        @(posedge _wr_en) disable iff (!arst_n)
        q_valid |-> (result == exp_word && carry == exp_carry
                     && zero == (exp_word == '0))
    ) else begin
        $error("ERR %0t: alu gave %0h c%0b z%0b, expected %0h c%0b", $time,
               $sampled(result), $sampled(carry), $sampled(zero),
               $sampled(exp_word), $sampled(exp_carry));
        fail_count++;
    end

endmodule

bind regfile_alu_top regfile_alu_sva #(
    .DATA_WIDTH (DATA_WIDTH)
) regfile_alu_sva_inst (
    ._wr_en   (_wr_en),
    .arst_n   (arst_n),
    .we       (we),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    ._rdl_en  (_rdl_en),
    .rdl_addr (rdl_addr),
    .rdl_data (rdl_data),
    ._rdr_en  (_rdr_en),
    .rdr_addr (rdr_addr),
    .rdr_data (rdr_data),
    .instr    (instr),
    .result   (result),
    .carry    (carry),
    .zero     (zero)
);

// ==== sim/regfile_alu_tb.sv ====
// testbench for the regfile/alu slice, directed and random stimulus checked by bound assertions
module regfile_alu_tb
    import regfile_alu_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PERIOD_NS      = 20;
    localparam int RESET_CYCLES   = 4;
    localparam int DRIVE_DELAY_NS = 2;
    localparam int N_RESET_SWEEP  = 4;
    localparam int N_WRITE_READ   = 16;
    localparam int N_CORNERS      = 7;
    localparam int N_PORTS        = 24;
    localparam int N_ALU_REG      = 32;
    localparam int N_ALU_IMM      = 16;
    localparam int N_RDW          = 8;
    localparam int N_TAIL         = 3;
    localparam int TOTAL_CYCLES   = N_RESET_SWEEP + N_WRITE_READ + N_CORNERS + N_PORTS
                                    + N_ALU_REG + N_ALU_IMM + N_RDW + N_TAIL;
    localparam int MARGIN_NS      = 400;

    logic                  _wr_en;
    logic                  arst_n;
    logic                  we;
    logic [ADDR_WIDTH-1:0] wr_addr;
    logic [DATA_WIDTH-1:0] wr_data;
    logic                  _rdl_en;
    logic [ADDR_WIDTH-1:0] rdl_addr;
    logic [DATA_WIDTH-1:0] rdl_data;
    logic                  _rdr_en;
    logic [ADDR_WIDTH-1:0] rdr_addr;
    logic [DATA_WIDTH-1:0] rdr_data;
    alu_instr_u            instr;
    logic [DATA_WIDTH-1:0] result;
    logic                  carry;
    logic                  zero;
    integer                seed;

    tb_clock_gen #(
        .PERIOD_NS        (PERIOD_NS),
        .RESET_CYCLES     (RESET_CYCLES),
        .RELEASE_DELAY_NS (DRIVE_DELAY_NS)
    ) tb_clock_gen_inst (
        ._wr_en (_wr_en),
        .arst_n (arst_n)
    );

    regfile_alu_top #(
        .DATA_WIDTH (DATA_WIDTH)
    ) regfile_alu_top_inst (
        ._wr_en   (_wr_en),
        .arst_n   (arst_n),
        .we       (we),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        ._rdl_en  (_rdl_en),
        .rdl_addr (rdl_addr),
        .rdl_data (rdl_data),
        ._rdr_en  (_rdr_en),
        .rdr_addr (rdr_addr),
        .rdr_data (rdr_data),
        .instr    (instr),
        .result   (result),
        .carry    (carry),
        .zero     (zero)
    );

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped on failure");
    endtask

    // inputs change a little after the edge
    task automatic next_cycle();
        @(posedge _wr_en);
        #(DRIVE_DELAY_NS);
    endtask

    function automatic logic [DATA_WIDTH-1:0] random_word();
        return DATA_WIDTH'($random(seed));
    endfunction

    function automatic alu_op_t random_op();
        logic [31:0] rnd;
        rnd = $random(seed);
        return alu_op_t'(rnd[2:0]);
    endfunction

    task automatic set_instr(input logic is_imm, input alu_op_t op, input logic [7:0] low);
        instr = {is_imm, op, low};
    endtask

    task automatic write_word(input int addr, input logic [DATA_WIDTH-1:0] data);
        next_cycle();
        we      = 1'b1;
        wr_addr = ADDR_WIDTH'(addr);
        wr_data = data;
        _rdl_en = 1'b1;
        _rdr_en = 1'b1;
        set_instr(1'b0, OP_PASS_L, 8'h00);
    endtask

    task automatic read_pair(input int l_addr, input int r_addr, input alu_op_t op);
        next_cycle();
        we       = 1'b0;
        _rdl_en  = 1'b0;
        _rdr_en  = 1'b0;
        rdl_addr = ADDR_WIDTH'(l_addr);
        rdr_addr = ADDR_WIDTH'(r_addr);
        set_instr(1'b0, op, 8'h00);
    endtask

    task automatic reset_sweep();
        for (int a = 0; a < N_RESET_SWEEP; a++) begin
            read_pair(a, N_RESET_SWEEP - 1 - a, OP_PASS_L);
        end
    endtask

    // both ports follow the previous write address
    task automatic write_read();
        logic [ADDR_WIDTH-1:0] last_addr;
        logic [31:0]           rnd;
        last_addr = '0;
        for (int n = 0; n < N_WRITE_READ; n++) begin
            next_cycle();
            rnd       = $random(seed);
            we        = (rnd[9:8] != 2'b00);
            wr_addr   = rnd[0 +: ADDR_WIDTH];
            wr_data   = random_word();
            _rdl_en   = 1'b0;
            _rdr_en   = 1'b0;
            rdl_addr  = last_addr;
            rdr_addr  = last_addr;
            set_instr(1'b0, OP_ADD, 8'h00);
            last_addr = wr_addr;
        end
    endtask

    // add overflow, subtract borrow, increment carry
    task automatic alu_corners();
        write_word(0, '1);
        write_word(1, DATA_WIDTH'(1));
        write_word(2, DATA_WIDTH'(1) << (DATA_WIDTH - 1));
        write_word(3, '0);
        read_pair(0, 1, OP_ADD);
        read_pair(3, 1, OP_SUB);
        read_pair(0, 2, OP_INC_L);
    endtask

    task automatic random_cycle(input logic is_imm, input logic rdr_may_idle);
        logic [31:0] rnd;
        rnd      = $random(seed);
        we       = rnd[0];
        wr_addr  = rnd[1 +: ADDR_WIDTH];
        wr_data  = random_word();
        rdl_addr = rnd[4:3];
        // right address always differs from the left one
        rdr_addr = rdl_addr + ADDR_WIDTH'(rnd[6:5] % 3) + 1'b1;
        _rdl_en  = 1'b0;
        _rdr_en  = rdr_may_idle & rnd[7];
        set_instr(is_imm, random_op(), rnd[15:8]);
    endtask

    task automatic independent_ports();
        logic [31:0] rnd;
        for (int n = 0; n < N_PORTS; n++) begin
            next_cycle();
            random_cycle(1'b0, 1'b1);
            rnd     = $random(seed);
            _rdl_en = (rnd[1:0] == 2'b00);
            _rdr_en = (rnd[3:2] == 2'b00);
        end
    endtask

    task automatic read_during_write();
        for (int n = 0; n < N_RDW; n++) begin
            next_cycle();
            random_cycle(1'b0, 1'b0);
            we      = 1'b1;
            wr_addr = rdl_addr;
        end
    endtask

    initial begin : stimulus
        seed     = 95;
        we       = 1'b0;
        wr_addr  = '0;
        wr_data  = '0;
        _rdl_en  = 1'b1;
        rdl_addr = '0;
        _rdr_en  = 1'b1;
        rdr_addr = '0;
        instr    = '0;
        @(posedge arst_n);
        reset_sweep();
        write_read();
        alu_corners();
        independent_ports();
        for (int n = 0; n < N_ALU_REG; n++) begin
            next_cycle();
            random_cycle(1'b0, 1'b0);
        end
        for (int n = 0; n < N_ALU_IMM; n++) begin
            next_cycle();
            random_cycle(1'b1, 1'b1);
        end
        read_during_write();
        for (int n = 0; n < N_TAIL; n++) begin
            read_pair(0, 1, OP_PASS_R);
        end
        if (regfile_alu_top_inst.regfile_alu_sva_inst.fail_count == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            report_failure("checks failed during the run");
        end
    end

    initial begin : failure_monitor
        wait (regfile_alu_top_inst.regfile_alu_sva_inst.fail_count != 0);
        report_failure("an assertion in the checker failed, see the ERR line above");
    end

    initial begin : watchdog
        #((RESET_CYCLES + TOTAL_CYCLES) * PERIOD_NS + MARGIN_NS);
        report_failure("timeout: the stimulus did not finish in the expected time");
    end

endmodule

// ==== sim/tb_clock_gen.sv ====
// testbench clock and reset source, free-running write strobe and a held-low reset
module tb_clock_gen #(
    parameter int PERIOD_NS        = 20,
    parameter int RESET_CYCLES     = 4,
    parameter int RELEASE_DELAY_NS = 2
) (
    output logic _wr_en,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        _wr_en = 1'b0;
        forever #(PERIOD_NS / 2) _wr_en = ~_wr_en;
    end

    // release away from the edge, like any other input
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge _wr_en);
        #(RELEASE_DELAY_NS);
        arst_n = 1'b1;
    end

endmodule
